// ==== sources.f ====
+incdir+.
csr_pkg.sv
csr_req_if.sv
csr_axil_front.sv
csr_req_fifo.sv
csr_perf_counters.sv
csr_file.sv
csr_unit_top.sv
tb_csr_unit.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_csr_unit
RTL_TOP  = csr_unit_top
FILELIST = sources.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_csr_tests.svh ====
////////////////////////////////////////////////////////////
// directed tests for the csr unit testbench
////////////////////////////////////////////////////////////
`ifndef TB_CSR_TESTS_SVH
`define TB_CSR_TESTS_SVH

task automatic test_reset_state();
  check_flag("s_awready_o", s_awready_o, 1'b0);
  check_flag("s_wready_o", s_wready_o, 1'b0);
  check_flag("s_arready_o", s_arready_o, 1'b0);
  check_flag("s_bvalid_o", s_bvalid_o, 1'b0);
  check_flag("s_rvalid_o", s_rvalid_o, 1'b0);
  check_flag("m_irq_enable_o", m_irq_enable_o, 1'b0);
  check_word("epc_o", epc_o, '0);
  check_word("mtvec_o", mtvec_o, '0);
endtask

task automatic test_write_set_clear();
  logic [XLEN-1:0] data;
  logic [XLEN-1:0] mask;
  logic [XLEN-1:0] exp;
  logic [XLEN-1:0] rd;
  data = rand_word();
  axil_write(CSR_OP_WRITE, CSR_MEPC, data);
  axil_read(CSR_MEPC, rd);
  check_word("mepc", rd, data);
  check_word("epc_o", epc_o, data);
  mask = rand_word();
  exp  = data | mask;
  axil_write(CSR_OP_SET, CSR_MEPC, mask);
  axil_read(CSR_MEPC, rd);
  check_word("mepc after set", rd, exp);
  mask = rand_word();
  exp  = exp & ~mask;
  axil_write(CSR_OP_CLEAR, CSR_MEPC, mask);
  axil_read(CSR_MEPC, rd);
  check_word("mepc after clear", rd, exp);
  // read-only hart id, write has no effect
  axil_write(CSR_OP_WRITE, CSR_MHARTID, rand_word());
  axil_read(CSR_MHARTID, rd);
  check_word("mhartid", rd, XLEN'(hart_id_i));
  axil_read(12'h123, rd);
  check_word("unmapped csr", rd, '0);
endtask

task automatic test_mstatus_mask();
  logic [XLEN-1:0] rd;
  axil_write(CSR_OP_WRITE, CSR_MSTATUS, '1);
  axil_read(CSR_MSTATUS, rd);
  // mie, mpie and mpp only
  check_word("mstatus", rd, 32'h0000_1888);
  check_flag("m_irq_enable_o", m_irq_enable_o, 1'b1);
endtask

task automatic test_trap_mret();
  logic [XLEN-1:0] rd;
  logic [XLEN-1:0] pc;
  mcause_t         cause;
  // mie set and mpie clear, so the trap has to move mie into mpie
  axil_write(CSR_OP_WRITE, CSR_MSTATUS, 32'h1 << MSTATUS_MIE_BIT);
  pc    = rand_word();
  cause = 6'h2B;
  trap_cause_i = cause;
  trap_pc_i    = pc;
  trap_i       = 1'b1;
  @(posedge clk);
  #10;
  trap_i = 1'b0;
  check_word("epc_o", epc_o, pc);
  check_flag("m_irq_enable_o", m_irq_enable_o, 1'b0);
  axil_read(CSR_MCAUSE, rd);
  // flag in bit 31, code 0x0b in the low bits
  check_word("mcause", rd, 32'h8000_000B);
  axil_read(CSR_MSTATUS, rd);
  check_word("mstatus after trap", rd, 32'h0000_1880);
  mret_i = 1'b1;
  @(posedge clk);
  #10;
  mret_i = 1'b0;
  check_flag("m_irq_enable_o", m_irq_enable_o, 1'b1);
  axil_read(CSR_MSTATUS, rd);
  check_word("mstatus after mret", rd, 32'h0000_1888);
endtask

task automatic pulse_events(input int loads, input int stores);
  for (int i = 0; i < loads + stores; i++) begin
    mem_load_i  = (i < loads);
    mem_store_i = (i >= loads);
    @(posedge clk);
    #10;
    mem_load_i  = 1'b0;
    mem_store_i = 1'b0;
    @(posedge clk);
    #10;
  end
endtask

task automatic test_event_counters();
  logic [XLEN-1:0] rd;
  axil_write(CSR_OP_WRITE, CSR_PCER, (32'h1 << PERF_LOAD) | (32'h1 << PERF_STORE));
  axil_write(CSR_OP_WRITE, CSR_PCCR_ALL, '0);
  pulse_events(5, 3);
  wait_cycles(2);
  axil_read(pccr_addr(PERF_LOAD), rd);
  check_word("load counter", rd, 32'd5);
  axil_read(pccr_addr(PERF_STORE), rd);
  check_word("store counter", rd, 32'd3);
  // loads masked off
  axil_write(CSR_OP_CLEAR, CSR_PCER, 32'h1 << PERF_LOAD);
  pulse_events(3, 0);
  wait_cycles(2);
  axil_read(pccr_addr(PERF_LOAD), rd);
  check_word("masked load counter", rd, 32'd5);
endtask

task automatic test_saturation();
  logic [XLEN-1:0] rd;
  axil_write(CSR_OP_SET, CSR_PCER, 32'h1 << PERF_LOAD);
  axil_write(CSR_OP_WRITE, pccr_addr(PERF_LOAD), '1);
  pulse_events(1, 0);
  wait_cycles(2);
  axil_read(pccr_addr(PERF_LOAD), rd);
  check_word("saturated load counter", rd, '1);
  axil_write(CSR_OP_CLEAR, CSR_PCMR, 32'h2);
  axil_read(CSR_PCMR, rd);
  check_word("pcmr", rd, 32'h1);
  pulse_events(1, 0);
  wait_cycles(2);
  axil_read(pccr_addr(PERF_LOAD), rd);
  check_word("wrapped load counter", rd, '0);
endtask

task automatic test_back_pressure();
  csr_addr_t       addrs [4];
  logic [XLEN-1:0] vals  [4];
  logic [XLEN-1:0] rd;
  int              b_cnt;
  logic            aw_hs;
  // cycle and instr counters are disabled, so they hold their value
  addrs = '{CSR_MTVEC, CSR_MEPC, pccr_addr(PERF_CYCLE), pccr_addr(PERF_INSTR)};
  for (int i = 0; i < 4; i++) begin
    vals[i] = rand_word();
  end
  s_bready_i = 1'b0;
  for (int i = 0; i < 3; i++) begin
    axil_send_write(CSR_OP_WRITE, addrs[i], vals[i]);
  end
  // response slot and buffer are full now
  s_awvalid_i = 1'b1;
  s_awaddr_i  = axi_addr(CSR_OP_WRITE, addrs[3]);
  s_wvalid_i  = 1'b1;
  s_wdata_i   = vals[3];
  repeat (3) begin
    @(negedge clk);
    check_flag("s_awready_o", s_awready_o, 1'b0);
  end
  @(posedge clk);
  #10;
  s_bready_i = 1'b1;
  b_cnt = 0;
  while (b_cnt < 4) begin
    @(negedge clk);
    aw_hs = s_awvalid_i & s_awready_o;
    if (s_bvalid_o) begin
      check_resp("s_bresp_o", s_bresp_o, AXI_RESP_OKAY);
      b_cnt++;
    end
    @(posedge clk);
    #10;
    if (aw_hs) begin
      s_awvalid_i = 1'b0;
      s_wvalid_i  = 1'b0;
    end
  end
  for (int i = 0; i < 4; i++) begin
    axil_read(addrs[i], rd);
    check_word($sformatf("readback %0d", i), rd, vals[i]);
  end
  check_word("mtvec_o", mtvec_o, vals[0]);
endtask

`endif

// ==== tb_csr_unit.sv ====
////////////////////////////////////////////////////////////
// testbench for the csr unit
// axi4-lite driver, compare tasks, lfsr data and timeout
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_csr_unit;
  import csr_pkg::*;

  localparam int TIMEOUT_CYCLES = 2000;

  logic                 clk;
  logic                 rst_n;
  logic                 s_awvalid_i;
  logic [AXI_AW-1:0]    s_awaddr_i;
  logic                 s_awready_o;
  logic                 s_wvalid_i;
  logic [XLEN-1:0]      s_wdata_i;
  logic                 s_wready_o;
  logic                 s_bvalid_o;
  logic [1:0]           s_bresp_o;
  logic                 s_bready_i;
  logic                 s_arvalid_i;
  logic [AXI_AW-1:0]    s_araddr_i;
  logic                 s_arready_o;
  logic                 s_rvalid_o;
  logic [XLEN-1:0]      s_rdata_o;
  logic [1:0]           s_rresp_o;
  logic                 s_rready_i;
  logic                 trap_i;
  mcause_t              trap_cause_i;
  logic [XLEN-1:0]      trap_pc_i;
  logic                 mret_i;
  logic                 instr_ret_i;
  logic                 mem_load_i;
  logic                 mem_store_i;
  logic [HART_ID_W-1:0] hart_id_i;
  logic [XLEN-1:0]      epc_o;
  logic [XLEN-1:0]      mtvec_o;
  logic                 m_irq_enable_o;

  logic [31:0] lfsr_q = 32'h2794;
  int          cycle_cnt = 0;

  csr_unit_top csr_unit_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // failure handling and compare tasks
  ////////////////////////////////////////////////////////////
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_word(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      fail_run("timeout: the tests did not finish within the cycle limit");
    end
  end

  // galois lfsr, one step per bit taken
  function logic [31:0] rand_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w = {w[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
    end
    return w;
  endfunction

  function automatic logic [AXI_AW-1:0] axi_addr(input csr_op_e op, input csr_addr_t addr);
    return {op, addr, 2'b00};
  endfunction

  function automatic csr_addr_t pccr_addr(input int id);
    return CSR_PCCR_BASE | csr_addr_t'(id);
  endfunction

  ////////////////////////////////////////////////////////////
  // axi4-lite driver, entered and left 10 ns after a rising edge
  ////////////////////////////////////////////////////////////
  task automatic axil_send_write(input csr_op_e op, input csr_addr_t addr,
                                 input logic [XLEN-1:0] data);
    s_awvalid_i = 1'b1;
    s_awaddr_i  = axi_addr(op, addr);
    s_wvalid_i  = 1'b1;
    s_wdata_i   = data;
    @(negedge clk);
    while (!(s_awready_o && s_wready_o)) @(negedge clk);
    @(posedge clk);
    #10;
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
  endtask

  task automatic axil_wait_b();
    @(negedge clk);
    while (!s_bvalid_o) @(negedge clk);
    check_resp("s_bresp_o", s_bresp_o, AXI_RESP_OKAY);
    @(posedge clk);
    #10;
  endtask

  task automatic axil_write(input csr_op_e op, input csr_addr_t addr,
                            input logic [XLEN-1:0] data);
    axil_send_write(op, addr, data);
    axil_wait_b();
  endtask

  task automatic axil_read(input csr_addr_t addr, output logic [XLEN-1:0] data);
    s_arvalid_i = 1'b1;
    s_araddr_i  = axi_addr(CSR_OP_NONE, addr);
    @(negedge clk);
    while (!s_arready_o) @(negedge clk);
    @(posedge clk);
    #10;
    s_arvalid_i = 1'b0;
    @(negedge clk);
    while (!s_rvalid_o) @(negedge clk);
    data = s_rdata_o;
    check_resp("s_rresp_o", s_rresp_o, AXI_RESP_OKAY);
    @(posedge clk);
    #10;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #10;
    end
  endtask

  `include "tb_csr_tests.svh"

  initial begin
    rst_n        = 1'b0;
    s_awvalid_i  = 1'b0;
    s_awaddr_i   = '0;
    s_wvalid_i   = 1'b0;
    s_wdata_i    = '0;
    s_bready_i   = 1'b1;
    s_arvalid_i  = 1'b0;
    s_araddr_i   = '0;
    s_rready_i   = 1'b1;
    trap_i       = 1'b0;
    trap_cause_i = '0;
    trap_pc_i    = '0;
    mret_i       = 1'b0;
    instr_ret_i  = 1'b0;
    mem_load_i   = 1'b0;
    mem_store_i  = 1'b0;
    hart_id_i    = 10'h2A5;
    repeat (10) @(posedge clk);
    #10;
    rst_n = 1'b1;

    test_reset_state();
    test_write_set_clear();
    test_mstatus_mask();
    test_trap_mret();
    test_event_counters();
    test_saturation();
    test_back_pressure();

    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== csr_unit_top.sv ====
////////////////////////////////////////////////////////////
// csr unit top, axi4-lite slave and core-side ports
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module csr_unit_top (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          s_awvalid_i,
  input  logic [csr_pkg::AXI_AW-1:0]    s_awaddr_i,
  output logic                          s_awready_o,
  input  logic                          s_wvalid_i,
  input  logic [csr_pkg::XLEN-1:0]      s_wdata_i,
  output logic                          s_wready_o,
  output logic                          s_bvalid_o,
  output logic [1:0]                    s_bresp_o,
  input  logic                          s_bready_i,
  input  logic                          s_arvalid_i,
  input  logic [csr_pkg::AXI_AW-1:0]    s_araddr_i,
  output logic                          s_arready_o,
  output logic                          s_rvalid_o,
  output logic [csr_pkg::XLEN-1:0]      s_rdata_o,
  output logic [1:0]                    s_rresp_o,
  input  logic                          s_rready_i,
  input  logic                          trap_i,
  input  csr_pkg::mcause_t              trap_cause_i,
  input  logic [csr_pkg::XLEN-1:0]      trap_pc_i,
  input  logic                          mret_i,
  input  logic                          instr_ret_i,
  input  logic                          mem_load_i,
  input  logic                          mem_store_i,
  input  logic [csr_pkg::HART_ID_W-1:0] hart_id_i,
  output logic [csr_pkg::XLEN-1:0]      epc_o,
  output logic [csr_pkg::XLEN-1:0]      mtvec_o,
  output logic                          m_irq_enable_o
);

  // front end to buffer, buffer to csr file
  csr_req_if front_req ();
  csr_req_if file_req ();

  csr_axil_front csr_axil_front_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .s_awvalid_i (s_awvalid_i),
    .s_awaddr_i  (s_awaddr_i),
    .s_awready_o (s_awready_o),
    .s_wvalid_i  (s_wvalid_i),
    .s_wdata_i   (s_wdata_i),
    .s_wready_o  (s_wready_o),
    .s_arvalid_i (s_arvalid_i),
    .s_araddr_i  (s_araddr_i),
    .s_arready_o (s_arready_o),
    .req         (front_req.src)
  );

  csr_req_fifo csr_req_fifo_i (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (front_req.dst),
    .out   (file_req.src)
  );

  csr_file csr_file_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .req            (file_req.dst),
    .s_bvalid_o     (s_bvalid_o),
    .s_bresp_o      (s_bresp_o),
    .s_bready_i     (s_bready_i),
    .s_rvalid_o     (s_rvalid_o),
    .s_rdata_o      (s_rdata_o),
    .s_rresp_o      (s_rresp_o),
    .s_rready_i     (s_rready_i),
    .trap_i         (trap_i),
    .trap_cause_i   (trap_cause_i),
    .trap_pc_i      (trap_pc_i),
    .mret_i         (mret_i),
    .instr_ret_i    (instr_ret_i),
    .mem_load_i     (mem_load_i),
    .mem_store_i    (mem_store_i),
    .hart_id_i      (hart_id_i),
    .epc_o          (epc_o),
    .mtvec_o        (mtvec_o),
    .m_irq_enable_o (m_irq_enable_o)
  );

endmodule

// ==== csr_file.sv ====
////////////////////////////////////////////////////////////
// machine mode csr file
// decode, read-modify-write, trap state and b/r responses
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module csr_file (
  input  logic                          clk,
  input  logic                          rst_n,
  csr_req_if.dst                        req,
  output logic                          s_bvalid_o,
  output logic [1:0]                    s_bresp_o,
  input  logic                          s_bready_i,
  output logic                          s_rvalid_o,
  output logic [csr_pkg::XLEN-1:0]      s_rdata_o,
  output logic [1:0]                    s_rresp_o,
  input  logic                          s_rready_i,
  input  logic                          trap_i,
  input  csr_pkg::mcause_t              trap_cause_i,
  input  logic [csr_pkg::XLEN-1:0]      trap_pc_i,
  input  logic                          mret_i,
  input  logic                          instr_ret_i,
  input  logic                          mem_load_i,
  input  logic                          mem_store_i,
  input  logic [csr_pkg::HART_ID_W-1:0] hart_id_i,
  output logic [csr_pkg::XLEN-1:0]      epc_o,
  output logic [csr_pkg::XLEN-1:0]      mtvec_o,
  output logic                          m_irq_enable_o
);
  import csr_pkg::*;

  logic            mie_q;
  logic            mpie_q;
  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] mepc_q;
  mcause_t         mcause_q;

  logic            resp_valid_q;
  logic            resp_write_q;
  logic [XLEN-1:0] resp_rdata_q;

  logic            resp_drain;
  logic            accept;
  logic            csr_we;
  csr_op_e         acc_op;
  logic            perf_sel;
  logic [XLEN-1:0] perf_rdata;
  logic [XLEN-1:0] old_val;
  logic [XLEN-1:0] new_val;
  csr_word_u       status_rd;
  csr_word_u       status_wr;

  // pop only when the response slot is free or drains now
  assign resp_drain = resp_valid_q & (resp_write_q ? s_bready_i : s_rready_i);
  assign req.ready  = ~resp_valid_q | resp_drain;
  assign accept     = req.valid & req.ready;
  assign acc_op     = req.is_write ? req.op : CSR_OP_NONE;
  assign csr_we     = accept & (acc_op != CSR_OP_NONE);

  ////////////////////////////////////////////////////////////
  // decode and old value
  ////////////////////////////////////////////////////////////
  always_comb begin
    status_rd        = '0;
    status_rd.ms.mie  = mie_q;
    status_rd.ms.mpie = mpie_q;
    // always machine mode
    status_rd.ms.mpp  = 2'b11;
  end

  always_comb begin
    case (req.addr)
      CSR_MSTATUS: old_val = status_rd.raw;
      CSR_MTVEC:   old_val = mtvec_q;
      CSR_MEPC:    old_val = mepc_q;
      CSR_MCAUSE:  old_val = {mcause_q[5], {(XLEN-6){1'b0}}, mcause_q[4:0]};
      CSR_MHARTID: old_val = {{(XLEN-HART_ID_W){1'b0}}, hart_id_i};
      default:     old_val = perf_sel ? perf_rdata : '0;
    endcase
  end

  assign new_val       = csr_apply_op(acc_op, old_val, req.wdata);
  assign status_wr.raw = new_val;

  csr_perf_counters csr_perf_counters_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .acc_valid_i (accept),
    .acc_op_i    (acc_op),
    .acc_addr_i  (req.addr),
    .acc_wdata_i (req.wdata),
    .sel_o       (perf_sel),
    .rdata_o     (perf_rdata),
    .instr_ret_i (instr_ret_i),
    .mem_load_i  (mem_load_i),
    .mem_store_i (mem_store_i)
  );

  ////////////////////////////////////////////////////////////
  // machine trap state
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mtvec_q  <= '0;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else begin
      if (csr_we && req.addr == CSR_MTVEC) begin
        mtvec_q <= new_val;
      end
      // trap and mret win over a csr write in the same cycle
      if (trap_i) begin
        mpie_q   <= mie_q;
        mie_q    <= 1'b0;
        mepc_q   <= trap_pc_i;
        mcause_q <= trap_cause_i;
      end else if (mret_i) begin
        mie_q  <= mpie_q;
        mpie_q <= 1'b1;
      end else if (csr_we) begin
        case (req.addr)
          CSR_MSTATUS: begin
            mie_q  <= status_wr.ms.mie;
            mpie_q <= status_wr.ms.mpie;
          end
          CSR_MEPC:   mepc_q   <= new_val;
          CSR_MCAUSE: mcause_q <= {new_val[XLEN-1], new_val[4:0]};
          default: ;
        endcase
      end
    end
  end

  // response slot, shared by b and r
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_valid_q <= 1'b0;
      resp_write_q <= 1'b0;
    end else if (accept) begin
      resp_valid_q <= 1'b1;
      resp_write_q <= req.is_write;
    end else if (resp_drain) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      resp_rdata_q <= old_val;
    end
  end

  assign s_bvalid_o = resp_valid_q & resp_write_q;
  assign s_bresp_o  = AXI_RESP_OKAY;
  assign s_rvalid_o = resp_valid_q & ~resp_write_q;
  assign s_rdata_o  = resp_rdata_q;
  assign s_rresp_o  = AXI_RESP_OKAY;

  assign epc_o          = mepc_q;
  assign mtvec_o        = mtvec_q;
  assign m_irq_enable_o = mie_q;

endmodule

// ==== csr_perf_counters.sv ====
////////////////////////////////////////////////////////////
// performance counters with event enable (pcer),
// mode register (pcmr) and optional saturation
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module csr_perf_counters (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     acc_valid_i,
  input  csr_pkg::csr_op_e         acc_op_i,
  input  csr_pkg::csr_addr_t       acc_addr_i,
  input  logic [csr_pkg::XLEN-1:0] acc_wdata_i,
  output logic                     sel_o,
  output logic [csr_pkg::XLEN-1:0] rdata_o,
  input  logic                     instr_ret_i,
  input  logic                     mem_load_i,
  input  logic                     mem_store_i
);
  import csr_pkg::*;

  logic [N_PERF-1:0] pcer_q;
  logic [1:0]        pcmr_q;
  logic [XLEN-1:0]   cnt_q [N_PERF];
  logic [N_PERF-1:0] ev;
  logic [N_PERF-1:0] inc_q;
  logic              is_pcer;
  logic              is_pcmr;
  logic              is_pccr;
  logic              pccr_all;
  logic [4:0]        pccr_idx;
  logic [XLEN-1:0]   pcer_new;
  logic [XLEN-1:0]   pcmr_new;

  assign ev[PERF_CYCLE] = 1'b1;
  assign ev[PERF_INSTR] = instr_ret_i;
  assign ev[PERF_LOAD]  = mem_load_i;
  assign ev[PERF_STORE] = mem_store_i;

  // 0x780 to 0x79f, the last one hits every counter
  assign is_pcer  = (acc_addr_i == CSR_PCER);
  assign is_pcmr  = (acc_addr_i == CSR_PCMR);
  assign is_pccr  = (acc_addr_i[CSR_AW-1:5] == CSR_PCCR_BASE[CSR_AW-1:5]);
  assign pccr_all = (acc_addr_i == CSR_PCCR_ALL);
  assign pccr_idx = acc_addr_i[4:0];
  assign sel_o    = is_pcer | is_pcmr | is_pccr;

  always_comb begin
    rdata_o = '0;
    if (is_pcer) begin
      rdata_o[N_PERF-1:0] = pcer_q;
    end else if (is_pcmr) begin
      rdata_o[1:0] = pcmr_q;
    end else if (is_pccr && pccr_idx < N_PERF) begin
      rdata_o = cnt_q[pccr_idx[$clog2(N_PERF)-1:0]];
    end
  end

  assign pcer_new = csr_apply_op(acc_op_i, {{(XLEN-N_PERF){1'b0}}, pcer_q}, acc_wdata_i);
  assign pcmr_new = csr_apply_op(acc_op_i, {{(XLEN-2){1'b0}}, pcmr_q}, acc_wdata_i);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pcer_q <= '0;
      pcmr_q <= PCMR_RESET;
      inc_q  <= '0;
      for (int i = 0; i < N_PERF; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      // events registered once, count lands a cycle later
      inc_q <= ev & pcer_q & {N_PERF{pcmr_q[0]}};
      if (acc_valid_i && is_pcer) begin
        pcer_q <= pcer_new[N_PERF-1:0];
      end
      if (acc_valid_i && is_pcmr) begin
        pcmr_q <= pcmr_new[1:0];
      end
      for (int i = 0; i < N_PERF; i++) begin
        if (acc_valid_i && acc_op_i != CSR_OP_NONE && is_pccr &&
            (pccr_all || pccr_idx == i)) begin
          cnt_q[i] <= csr_apply_op(acc_op_i, cnt_q[i], acc_wdata_i);
        end else if (inc_q[i] && (cnt_q[i] != '1 || !pcmr_q[1])) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

endmodule

// ==== csr_req_fifo.sv ====
////////////////////////////////////////////////////////////
// two-entry csr request buffer
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module csr_req_fifo (
  input  logic   clk,
  input  logic   rst_n,
  csr_req_if.dst in,
  csr_req_if.src out
);
  import csr_pkg::*;

  logic            is_write_mem [2];
  csr_op_e         op_mem       [2];
  csr_addr_t       addr_mem     [2];
  logic [XLEN-1:0] wdata_mem    [2];

  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;
  logic       push;
  logic       pop;

  assign in.ready  = (count_q != 2'd2);
  assign out.valid = (count_q != 2'd0);
  assign push      = in.valid & in.ready;
  assign pop       = out.valid & out.ready;

  assign out.is_write = is_write_mem[rd_ptr_q];
  assign out.op       = op_mem[rd_ptr_q];
  assign out.addr     = addr_mem[rd_ptr_q];
  assign out.wdata    = wdata_mem[rd_ptr_q];

  // storage
  always_ff @(posedge clk) begin
    if (push) begin
      is_write_mem[wr_ptr_q] <= in.is_write;
      op_mem[wr_ptr_q]       <= in.op;
      addr_mem[wr_ptr_q]     <= in.addr;
      wdata_mem[wr_ptr_q]    <= in.wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: ;
      endcase
    end
  end

endmodule

// ==== csr_axil_front.sv ====
////////////////////////////////////////////////////////////
// axi4-lite front end of the csr unit
// picks a paired aw/w write or an ar read, writes first,
// and splits the address into op and csr address
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module csr_axil_front (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        s_awvalid_i,
  input  logic [csr_pkg::AXI_AW-1:0]  s_awaddr_i,
  output logic                        s_awready_o,
  input  logic                        s_wvalid_i,
  input  logic [csr_pkg::XLEN-1:0]    s_wdata_i,
  output logic                        s_wready_o,
  input  logic                        s_arvalid_i,
  input  logic [csr_pkg::AXI_AW-1:0]  s_araddr_i,
  output logic                        s_arready_o,
  csr_req_if.src                      req
);
  import csr_pkg::*;

  logic wr_pair;
  logic wr_pend;
  logic sel_wr;
  logic sel_rd;
  logic rd_lock_q;

  assign wr_pair = s_awvalid_i & s_wvalid_i;
  assign wr_pend = s_awvalid_i | s_wvalid_i;

  // a read that was offered and stalled keeps the channel,
  // so a late write cannot change the fields under it
  assign sel_wr = wr_pair & ~rd_lock_q;
  assign sel_rd = s_arvalid_i & ~sel_wr & (rd_lock_q | ~wr_pend);

  ////////////////////////////////////////////////////////////
  // request fields
  ////////////////////////////////////////////////////////////
  assign req.valid    = sel_wr | sel_rd;
  assign req.is_write = sel_wr;
  assign req.op       = sel_wr ? csr_op_e'(s_awaddr_i[AXI_AW-1:AXI_AW-2]) : CSR_OP_NONE;
  assign req.addr     = sel_wr ? s_awaddr_i[CSR_AW+1:2] : s_araddr_i[CSR_AW+1:2];
  // strobes ignored, whole word always
  assign req.wdata    = s_wdata_i;

  // aw and w accepted together
  assign s_awready_o = sel_wr & req.ready;
  assign s_wready_o  = sel_wr & req.ready;
  assign s_arready_o = sel_rd & req.ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_lock_q <= 1'b0;
    end else begin
      rd_lock_q <= sel_rd & ~req.ready;
    end
  end

endmodule

// ==== csr_req_if.sv ====
////////////////////////////////////////////////////////////
// csr request channel with valid/ready handshake
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

interface csr_req_if;
  import csr_pkg::*;

  logic            valid;
  logic            ready;
  logic            is_write;
  csr_op_e         op;
  csr_addr_t       addr;
  logic [XLEN-1:0] wdata;

  modport src (
    output valid,
    output is_write,
    output op,
    output addr,
    output wdata,
    input  ready
  );

  modport dst (
    input  valid,
    input  is_write,
    input  op,
    input  addr,
    input  wdata,
    output ready
  );

endinterface

// ==== csr_pkg.sv ====
////////////////////////////////////////////////////////////
// csr unit shared definitions
// address map, op codes, widths and the mstatus word view
////////////////////////////////////////////////////////////
package csr_pkg;

  localparam int XLEN      = 32;
  localparam int CSR_AW    = 12;
  // byte address: op in 15:14, csr address in 13:2
  localparam int AXI_AW    = 16;
  localparam int HART_ID_W = 10;

  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

  typedef logic [CSR_AW-1:0] csr_addr_t;

  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  // machine mode map
  localparam csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam csr_addr_t CSR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_MHARTID   = 12'hF14;
  localparam csr_addr_t CSR_PCER      = 12'h7A0;
  localparam csr_addr_t CSR_PCMR      = 12'h7A1;
  localparam csr_addr_t CSR_PCCR_BASE = 12'h780;
  localparam csr_addr_t CSR_PCCR_ALL  = 12'h79F;

  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;

  localparam int N_PERF     = 4;
  localparam int PERF_CYCLE = 0;
  localparam int PERF_INSTR = 1;
  localparam int PERF_LOAD  = 2;
  localparam int PERF_STORE = 3;

  // global enable in bit 0, saturate in bit 1
  localparam logic [1:0] PCMR_RESET = 2'b11;

  // interrupt flag in bit 5, code below
  typedef logic [5:0] mcause_t;

  typedef union packed {
    logic [XLEN-1:0] raw;
    struct packed {
      logic [XLEN-14:0]                             rsv_hi;
      logic [1:0]                                   mpp;
      logic [2:0]                                   rsv_pp;
      logic                                         mpie;
      logic [MSTATUS_MPIE_BIT-MSTATUS_MIE_BIT-2:0] rsv_mid;
      logic                                         mie;
      logic [MSTATUS_MIE_BIT-1:0]                   rsv_lo;
    } ms;
  } csr_word_u;

  // read-modify-write by op, none keeps the old value
  function automatic logic [XLEN-1:0] csr_apply_op(csr_op_e op, logic [XLEN-1:0] old_val,
                                                   logic [XLEN-1:0] data);
    logic [XLEN-1:0] res;
    case (op)
      CSR_OP_WRITE: res = data;
      CSR_OP_SET:   res = old_val | data;
      CSR_OP_CLEAR: res = old_val & ~data;
      default:      res = old_val;
    endcase
    return res;
  endfunction

endpackage
